//--- axi_rd_xbar.f
+incdir+verilog
verilog/axi_rd_pkg.sv
verilog/xbar_ctrl_pkg.sv
verilog/ar_request_decoder.sv
verilog/ar_slave_arbiter.sv
verilog/r_response_router.sv
verilog/axi_rd_xbar.sv
verification/axi_rd_xbar_asserts.sv
verification/axi_rd_xbar_tb.sv

//--- verification/axi_rd_xbar_asserts.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module axi_rd_xbar_asserts
    import axi_rd_pkg::*;
(
    input logic                        aclk_i,
    input logic                        rst_n_i,
    input slv_ar_t [`XBAR_NUM_SLV-1:0] m_ar_o,
    input logic    [`XBAR_NUM_SLV-1:0] m_ar_valid_o,
    input logic    [`XBAR_NUM_SLV-1:0] m_ar_ready_i,
    input mst_r_t  [`XBAR_NUM_MST-1:0] s_r_o,
    input logic    [`XBAR_NUM_MST-1:0] s_r_valid_o,
    input logic    [`XBAR_NUM_MST-1:0] s_r_ready_i
);

    genvar g;

    // ==================================================
    // Slave read address, held until the transfer
    // ==================================================
    generate
        for (g = 0; g < `XBAR_NUM_SLV; g = g + 1) begin : g_ar_stable
            a_ar_stable: assert property (
                @(posedge aclk_i) disable iff (!rst_n_i)
                (m_ar_valid_o[g] && !m_ar_ready_i[g])
                |=> (m_ar_valid_o[g] && $stable(m_ar_o[g])))
                else $error("m_ar_o[%0d] changed while waiting for m_ar_ready_i", g);
        end
    endgenerate

    // ==================================================
    // Master read data slot, held until the transfer
    // ==================================================
    generate
        for (g = 0; g < `XBAR_NUM_MST; g = g + 1) begin : g_r_stable
            a_r_stable: assert property (
                @(posedge aclk_i) disable iff (!rst_n_i)
                (s_r_valid_o[g] && !s_r_ready_i[g])
                |=> (s_r_valid_o[g] && $stable(s_r_o[g])))
                else $error("s_r_o[%0d] changed while waiting for s_r_ready_i", g);
        end
    endgenerate

endmodule

bind axi_rd_xbar axi_rd_xbar_asserts axi_rd_xbar_asserts_i (
    .aclk_i      (aclk_i),
    .rst_n_i     (rst_n_i),
    .m_ar_o      (m_ar_o),
    .m_ar_valid_o(m_ar_valid_o),
    .m_ar_ready_i(m_ar_ready_i),
    .s_r_o       (s_r_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i)
);

//--- verification/axi_rd_xbar_patterns.txt
// Columns in hex: test master id addr stall_mask expected_data
// stall_mask bits [1:0] hold m_ar_ready per slave, bits [3:2] hold s_r_ready per master
1 0 1 0010 0 00000010
1 0 2 8020 0 00018020
1 1 3 0030 0 00000030
1 1 0 8040 0 00018040
2 0 0 0050 0 00000050
2 0 1 0054 0 00000054
2 1 3 005c 0 0000005c
2 1 0 0060 0 00000060
3 0 0 8100 2 00018100
3 0 1 8110 2 00018110
3 0 2 0120 2 00000120
3 0 3 8130 2 00018130
3 1 1 8140 2 00018140
3 1 2 8150 2 00018150
3 1 3 8160 2 00018160
4 0 0 0200 c 00000200
4 0 1 8210 c 00018210
4 1 3 8230 c 00018230
4 1 0 0240 c 00000240
5 0 2 0300 8 00000300
5 1 0 8310 8 00018310
5 1 1 0320 8 00000320

//--- verification/axi_rd_xbar_tb.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module axi_rd_xbar_tb
    import axi_rd_pkg::*;
();

    localparam int MAX_PAT   = 64;
    localparam int STALL_CYC = 20;
    localparam int FIFO_D    = 16;

    logic                        aclk;
    logic                        rst_n;
    mst_ar_t [`XBAR_NUM_MST-1:0] s_ar;
    logic    [`XBAR_NUM_MST-1:0] s_ar_valid;
    logic    [`XBAR_NUM_MST-1:0] s_ar_ready;
    mst_r_t  [`XBAR_NUM_MST-1:0] s_r;
    logic    [`XBAR_NUM_MST-1:0] s_r_valid;
    logic    [`XBAR_NUM_MST-1:0] s_r_ready;
    slv_ar_t [`XBAR_NUM_SLV-1:0] m_ar;
    logic    [`XBAR_NUM_SLV-1:0] m_ar_valid;
    logic    [`XBAR_NUM_SLV-1:0] m_ar_ready;
    slv_r_t  [`XBAR_NUM_SLV-1:0] m_r;
    logic    [`XBAR_NUM_SLV-1:0] m_r_valid;
    logic    [`XBAR_NUM_SLV-1:0] m_r_ready;

    // Six words per pattern line
    logic [31:0] pat_mem [6*MAX_PAT];
    int          n_pat;
    int          cur_idx [MAX_PAT];
    int          cur_n;
    logic        r_seen  [MAX_PAT];

    int   acc_cnt    [`XBAR_NUM_MST];
    int   pend       [`XBAR_NUM_MST][`XBAR_NUM_SLV];
    int   last_win   [`XBAR_NUM_SLV];
    int   snap_other [`XBAR_NUM_SLV];
    logic have_win   [`XBAR_NUM_SLV];
    int   r_cnt;

    // Slave model response FIFOs
    slv_r_t rsp_fifo [`XBAR_NUM_SLV][FIFO_D];
    int     rsp_dly  [`XBAR_NUM_SLV][FIFO_D];
    int     wr_p     [`XBAR_NUM_SLV];
    int     rd_p     [`XBAR_NUM_SLV];
    int     fill     [`XBAR_NUM_SLV];
    logic   r_taken  [`XBAR_NUM_SLV];

    // Slave response delay per pattern line
    int     ar_dly   [MAX_PAT];

    logic   [`XBAR_NUM_MST-1:0] prev_valid;
    logic   [`XBAR_NUM_MST-1:0] prev_ready;
    mst_r_t [`XBAR_NUM_MST-1:0] prev_r;

    int n_err;
    int n_checks;
    int cyc;
    int cycle_limit;

    always #50 aclk = ~aclk;

    axi_rd_xbar axi_rd_xbar_i (
        .aclk_i      (aclk),
        .rst_n_i     (rst_n),
        .s_ar_i      (s_ar),
        .s_ar_valid_i(s_ar_valid),
        .s_ar_ready_o(s_ar_ready),
        .s_r_o       (s_r),
        .s_r_valid_o (s_r_valid),
        .s_r_ready_i (s_r_ready),
        .m_ar_o      (m_ar),
        .m_ar_valid_o(m_ar_valid),
        .m_ar_ready_i(m_ar_ready),
        .m_r_i       (m_r),
        .m_r_valid_i (m_r_valid),
        .m_r_ready_o (m_r_ready)
    );

    function automatic logic [31:0] pat_field(input int i, input int k);
        return pat_mem[6 * i + k];
    endfunction

    // Addresses are unique within a test
    function automatic int find_by_addr(input logic [15:0] a);
        int hit;
        hit = -1;
        for (int k = 0; k < cur_n; k++) begin
            if (pat_field(cur_idx[k], 3) == a) begin
                hit = cur_idx[k];
            end
        end
        return hit;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
        n_checks++;
        if (got_v !== exp_v) begin
            n_err++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, got_v);
        end
    endtask

    task automatic drive_master(input int m);
        int i;
        for (int k = 0; k < cur_n; k++) begin
            i = cur_idx[k];
            if (pat_field(i, 1) == m) begin
                @(negedge aclk);
                s_ar[m].id    = `XBAR_ID_W'(pat_field(i, 2));
                s_ar[m].addr  = `XBAR_ADDR_W'(pat_field(i, 3));
                s_ar_valid[m] = 1'b1;
                @(posedge aclk);
                while (!s_ar_ready[m]) @(posedge aclk);
            end
        end
        @(negedge aclk);
        s_ar_valid[m] = 1'b0;
    endtask

    // Expected handshakes per master follow from the credit count
    task automatic hold_and_release(input logic [3:0] mask);
        int   exp_acc;
        int   i;
        int   d;
        logic blocked;
        int   used [`XBAR_NUM_SLV];
        if (mask != '0) begin
            repeat (STALL_CYC) @(negedge aclk);
            for (int m = 0; m < `XBAR_NUM_MST && mask[1:0] != '0; m++) begin
                exp_acc = 0;
                blocked = 1'b0;
                for (int s = 0; s < `XBAR_NUM_SLV; s++) used[s] = 0;
                for (int k = 0; k < cur_n; k++) begin
                    i = cur_idx[k];
                    d = (pat_field(i, 3) >> (`XBAR_ADDR_W - 1)) & 32'd1;
                    if (!blocked && pat_field(i, 1) == m) begin
                        if (mask[d] && used[d] >= `XBAR_CREDITS) begin
                            blocked = 1'b1;
                        end else begin
                            used[d]++;
                            exp_acc++;
                        end
                    end
                end
                check_val($sformatf("s_ar_ready_o[%0d] handshakes", m), exp_acc, acc_cnt[m]);
                if (blocked) begin
                    check_val($sformatf("s_ar_ready_o[%0d]", m), 0, s_ar_ready[m]);
                end
            end
            m_ar_ready = '1;
            s_r_ready  = '1;
        end
    endtask

    task automatic run_test(input int t);
        logic [3:0] mask;
        int         start_err;
        cur_n = 0;
        for (int i = 0; i < n_pat; i++) begin
            if (pat_field(i, 0) == t) begin
                cur_idx[cur_n] = i;
                cur_n++;
            end
        end
        if (cur_n > 0) begin
            start_err = n_err;
            mask      = 4'(pat_field(cur_idx[0], 4));
            r_cnt     = 0;
            for (int m = 0; m < `XBAR_NUM_MST; m++) acc_cnt[m] = 0;
            @(negedge aclk);
            for (int s = 0; s < `XBAR_NUM_SLV; s++) m_ar_ready[s] = !mask[s];
            for (int m = 0; m < `XBAR_NUM_MST; m++) s_r_ready[m] = !mask[`XBAR_NUM_SLV + m];
            fork
                drive_master(0);
                drive_master(1);
                hold_and_release(mask);
            join
            while (r_cnt < cur_n) @(negedge aclk);
            $display("test %0d: %0d reads, stall mask %h, %0d errors",
                     t, cur_n, mask, n_err - start_err);
        end
    endtask

    // ==================================================
    // Monitor and slave models
    // ==================================================
    always @(posedge aclk) begin
        int w;
        int i;
        int d;
        if (rst_n) begin
            for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
                if (m_ar_valid[s] && m_ar_ready[s]) begin
                    w = int'(m_ar[s].id[`XBAR_ID_W]);
                    i = find_by_addr(m_ar[s].addr);
                    if (i < 0) begin
                        n_err++;
                        $display("Slave %0d got address %h that no master sent", s, m_ar[s].addr);
                    end else begin
                        check_val("m_ar_o.id", (pat_field(i, 1) << `XBAR_ID_W) | pat_field(i, 2),
                                  m_ar[s].id);
                        check_val("m_ar_o.addr top bit", s, m_ar[s].addr[`XBAR_ADDR_W-1]);
                    end
                    // Other master was already queued at the previous grant
                    if (have_win[s] && last_win[s] == w && snap_other[s] > 0) begin
                        n_err++;
                        $display("Slave %0d served master %0d twice while the other waited", s, w);
                    end
                    have_win[s]   = 1'b1;
                    last_win[s]   = w;
                    snap_other[s] = pend[(w + 1) % `XBAR_NUM_MST][s];
                    pend[w][s]--;
                    rsp_fifo[s][wr_p[s]].id   = m_ar[s].id;
                    rsp_fifo[s][wr_p[s]].data = {16'(s), m_ar[s].addr};
                    rsp_fifo[s][wr_p[s]].resp = OKAY;
                    rsp_dly[s][wr_p[s]]       = (i < 0) ? 0 : ar_dly[i];
                    wr_p[s] = (wr_p[s] + 1) % FIFO_D;
                    fill[s]++;
                end
                // A full and stalled master slot blocks every slave addressing it
                if (m_r_valid[s]) begin
                    w = int'(m_r[s].id[`XBAR_ID_W]);
                    if (s_r_valid[w] && !s_r_ready[w]) begin
                        check_val($sformatf("m_r_ready_o[%0d]", s), 0, m_r_ready[s]);
                    end
                end
                if (m_r_valid[s] && m_r_ready[s]) begin
                    r_taken[s] = 1'b1;
                end
            end
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                if (s_ar_valid[m] && s_ar_ready[m]) begin
                    d = int'(s_ar[m].addr[`XBAR_ADDR_W-1]);
                    acc_cnt[m]++;
                    pend[m][d]++;
                end
                if (s_r_valid[m] && s_r_ready[m]) begin
                    i = find_by_addr(s_r[m].data[15:0]);
                    if (i < 0 || r_seen[i] || pat_field(i, 1) != m) begin
                        n_err++;
                        $display("Master %0d got an unexpected response for address %h",
                                 m, s_r[m].data[15:0]);
                    end else begin
                        r_seen[i] = 1'b1;
                        r_cnt++;
                        check_val("s_r_o.id", pat_field(i, 2), s_r[m].id);
                        check_val("s_r_o.data", pat_field(i, 5), s_r[m].data);
                        check_val("s_r_o.resp", OKAY, s_r[m].resp);
                    end
                end
                if (prev_valid[m] && !prev_ready[m]) begin
                    check_val("s_r_valid_o", 1, s_r_valid[m]);
                    check_val("s_r_o", prev_r[m], s_r[m]);
                end
            end
            prev_valid = s_r_valid;
            prev_ready = s_r_ready;
            prev_r     = s_r;
        end
    end

    // Each slave answers in order after a random delay
    always @(negedge aclk) begin
        for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
            if (r_taken[s]) begin
                r_taken[s]   = 1'b0;
                m_r_valid[s] = 1'b0;
                rd_p[s]      = (rd_p[s] + 1) % FIFO_D;
                fill[s]--;
            end
            if (!m_r_valid[s] && fill[s] > 0) begin
                if (rsp_dly[s][rd_p[s]] > 0) begin
                    rsp_dly[s][rd_p[s]]--;
                end else begin
                    m_r[s]       = rsp_fifo[s][rd_p[s]];
                    m_r_valid[s] = 1'b1;
                end
            end
        end
    end

    always @(posedge aclk) begin
        cyc++;
        if (cyc > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int t_err;
        int last_test;
        int n_tests;
        int n_failed;
        aclk       = 1'b0;
        rst_n      = 1'b0;
        s_ar       = '0;
        s_ar_valid = '0;
        s_r_ready  = '1;
        m_ar_ready = '1;
        m_r        = '0;
        m_r_valid  = '0;
        prev_valid = '0;
        prev_ready = '1;
        prev_r     = '0;
        n_err      = 0;
        n_checks   = 0;
        cyc        = 0;
        r_cnt      = 0;
        cur_n      = 0;
        n_failed   = 0;
        for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
            wr_p[s]       = 0;
            rd_p[s]       = 0;
            fill[s]       = 0;
            r_taken[s]    = 1'b0;
            have_win[s]   = 1'b0;
            last_win[s]   = 0;
            snap_other[s] = 0;
            for (int m = 0; m < `XBAR_NUM_MST; m++) pend[m][s] = 0;
        end
        for (int m = 0; m < `XBAR_NUM_MST; m++) acc_cnt[m] = 0;
        for (int i = 0; i < MAX_PAT; i++) r_seen[i] = 1'b0;
        void'($urandom(32'hfd627a0e));
        for (int k = 0; k < MAX_PAT; k++) begin
            ar_dly[k] = $urandom % 4;
        end
        for (int w = 0; w < 6 * MAX_PAT; w++) pat_mem[w] = '1;
        $readmemh("verification/axi_rd_xbar_patterns.txt", pat_mem);
        n_pat = 0;
        while (n_pat < MAX_PAT && pat_mem[6 * n_pat] != '1) n_pat++;
        cycle_limit = 40 * n_pat + 200;
        if (n_pat == 0) begin
            n_err++;
            $display("No pattern lines could be read from the pattern file");
        end
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        // Idle outputs before any request
        @(negedge aclk);
        t_err = n_err;
        check_val("m_ar_valid_o", 0, m_ar_valid);
        check_val("s_r_valid_o", 0, s_r_valid);
        $display("test 0: idle after reset, %0d errors", n_err - t_err);
        n_tests = 1;
        if (n_err != t_err) n_failed++;

        last_test = (n_pat > 0) ? int'(pat_field(n_pat - 1, 0)) : 0;
        for (int t = 1; t <= last_test; t++) begin
            t_err = n_err;
            run_test(t);
            n_tests++;
            if (n_err != t_err) n_failed++;
        end

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 n_tests, n_failed, n_checks, n_err);
        if (n_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/ar_request_decoder.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module ar_request_decoder
    import axi_rd_pkg::*;
    import xbar_ctrl_pkg::*;
(
    input  logic                                              aclk_i,
    input  logic                                              rst_n_i,
    // ==================================================
    // Master read address channels
    // ==================================================
    input  mst_ar_t   [`XBAR_NUM_MST-1:0]                     s_ar_i,
    input  logic      [`XBAR_NUM_MST-1:0]                     s_ar_valid_i,
    output logic      [`XBAR_NUM_MST-1:0]                     s_ar_ready_o,
    // ==================================================
    // Request pushes and credit returns, per slave
    // ==================================================
    output logic      [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0]  req_push_o,
    output xbar_req_t [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0]  req_o,
    input  logic      [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0]  credit_ret_i
);

    slv_idx_t    [`XBAR_NUM_MST-1:0]                     dst_slv;
    logic        [`XBAR_NUM_MST-1:0]                     s_ar_hs;
    logic        [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0]  take;
    credit_cnt_t [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0]  credit_q;
    xbar_req_t   [`XBAR_NUM_MST-1:0]                     req_q;

    // Target slave is the top address bits
    always_comb begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            dst_slv[m]      = s_ar_i[m].addr[`XBAR_ADDR_W-1 -: `XBAR_SLV_IDX_W];
            s_ar_ready_o[m] = (credit_q[dst_slv[m]][m] != '0);
            s_ar_hs[m]      = s_ar_valid_i[m] && s_ar_ready_o[m];
        end
    end

    always_comb begin
        for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                take[s][m] = s_ar_hs[m] && (dst_slv[m] == slv_idx_t'(s));
            end
        end
    end

    // Credit per master/slave pair
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
                for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                    credit_q[s][m] <= credit_cnt_t'(`XBAR_CREDITS);
                end
            end
        end else begin
            for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
                for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                    credit_q[s][m] <= credit_q[s][m]
                                      + credit_cnt_t'(credit_ret_i[s][m])
                                      - credit_cnt_t'(take[s][m]);
                end
            end
        end
    end

    // Push lands in the arbiter queue one cycle after the handshake
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_push_o <= '0;
        end else begin
            req_push_o <= take;
        end
    end

    always_ff @(posedge aclk_i) begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            if (s_ar_hs[m]) begin
                req_q[m].ar <= s_ar_i[m];
            end
        end
    end

    // Same payload goes to every slave, only the push selects
    always_comb begin
        for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                req_o[s][m] = req_q[m];
            end
        end
    end

endmodule

//--- verilog/ar_slave_arbiter.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module ar_slave_arbiter
    import axi_rd_pkg::*;
    import xbar_ctrl_pkg::*;
(
    input  logic                          aclk_i,
    input  logic                          rst_n_i,
    // ==================================================
    // Requests from the decoder
    // ==================================================
    input  logic      [`XBAR_NUM_MST-1:0] req_push_i,
    input  xbar_req_t [`XBAR_NUM_MST-1:0] req_i,
    output logic      [`XBAR_NUM_MST-1:0] credit_ret_o,
    // ==================================================
    // Slave read address channel
    // ==================================================
    output slv_ar_t                       m_ar_o,
    output logic                          m_ar_valid_o,
    input  logic                          m_ar_ready_i
);

    localparam int PTR_W = $clog2(`XBAR_CREDITS);

    xbar_req_t        q_mem    [`XBAR_NUM_MST][`XBAR_CREDITS];
    logic [PTR_W-1:0] wr_ptr_q [`XBAR_NUM_MST];
    logic [PTR_W-1:0] rd_ptr_q [`XBAR_NUM_MST];
    credit_cnt_t      fill_q   [`XBAR_NUM_MST];

    logic [`XBAR_NUM_MST-1:0] not_empty;
    arb_state_e               state_q;
    mst_idx_t                 grant_q;
    mst_idx_t                 last_q;
    mst_idx_t                 pick;
    logic                     pick_vld;
    xbar_req_t                head;
    logic                     ar_hs;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`XBAR_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ar_hs = m_ar_valid_o && m_ar_ready_i;

    // Entry leaves its queue and the credit goes back in the same cycle
    always_comb begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            not_empty[m]    = (fill_q[m] != '0);
            credit_ret_o[m] = ar_hs && (grant_q == mst_idx_t'(m));
        end
    end

    // Round robin, starting after the last winner
    always_comb begin
        mst_idx_t cand;
        pick     = last_q;
        pick_vld = 1'b0;
        for (int k = 1; k <= `XBAR_NUM_MST; k++) begin
            cand = mst_idx_t'((int'(last_q) + k) % `XBAR_NUM_MST);
            if (!pick_vld && not_empty[cand]) begin
                pick     = cand;
                pick_vld = 1'b1;
            end
        end
    end

    assign head = q_mem[pick][rd_ptr_q[pick]];

    // ==================================================
    // Per-master request queues
    // ==================================================
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                wr_ptr_q[m] <= '0;
                rd_ptr_q[m] <= '0;
                fill_q[m]   <= '0;
            end
        end else begin
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                if (req_push_i[m]) begin
                    wr_ptr_q[m] <= ptr_inc(wr_ptr_q[m]);
                end
                if (credit_ret_o[m]) begin
                    rd_ptr_q[m] <= ptr_inc(rd_ptr_q[m]);
                end
                fill_q[m] <= fill_q[m] + credit_cnt_t'(req_push_i[m])
                             - credit_cnt_t'(credit_ret_o[m]);
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            if (req_push_i[m]) begin
                q_mem[m][wr_ptr_q[m]] <= req_i[m];
            end
        end
    end

    // ==================================================
    // Grant FSM
    // ==================================================
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ARB_IDLE;
            grant_q      <= '0;
            // Master 0 wins the first round
            last_q       <= mst_idx_t'(`XBAR_NUM_MST - 1);
            m_ar_valid_o <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (pick_vld) begin
                        grant_q      <= pick;
                        m_ar_valid_o <= 1'b1;
                        state_q      <= ARB_HOLD;
                    end
                end
                ARB_HOLD: begin
                    if (ar_hs) begin
                        last_q       <= grant_q;
                        m_ar_valid_o <= 1'b0;
                        state_q      <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Head of the granted queue, ID widened with the master index
    always_ff @(posedge aclk_i) begin
        if (state_q == ARB_IDLE && pick_vld) begin
            m_ar_o.id   <= {pick, head.ar.id};
            m_ar_o.addr <= head.ar.addr;
        end
    end

endmodule

//--- verilog/axi_rd_pkg.sv
`include "xbar_defines.svh"

package axi_rd_pkg;

    // AXI read response code
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // ==================================================
    // Master side beats
    // ==================================================
    typedef struct packed {
        logic [`XBAR_ID_W-1:0]   id;
        logic [`XBAR_ADDR_W-1:0] addr;
    } mst_ar_t;

    typedef struct packed {
        logic [`XBAR_ID_W-1:0]   id;
        logic [`XBAR_DATA_W-1:0] data;
        axi_resp_e               resp;
    } mst_r_t;

    // ==================================================
    // Slave side beats, ID widened by the master index
    // ==================================================
    typedef struct packed {
        logic [`XBAR_MST_IDX_W+`XBAR_ID_W-1:0] id;
        logic [`XBAR_ADDR_W-1:0]               addr;
    } slv_ar_t;

    typedef struct packed {
        logic [`XBAR_MST_IDX_W+`XBAR_ID_W-1:0] id;
        logic [`XBAR_DATA_W-1:0]               data;
        axi_resp_e                             resp;
    } slv_r_t;

endpackage

//--- verilog/axi_rd_xbar.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module axi_rd_xbar
    import axi_rd_pkg::*;
    import xbar_ctrl_pkg::*;
(
    input  logic                        aclk_i,
    input  logic                        rst_n_i,
    // ==================================================
    // Master ports
    // ==================================================
    input  mst_ar_t [`XBAR_NUM_MST-1:0] s_ar_i,
    input  logic    [`XBAR_NUM_MST-1:0] s_ar_valid_i,
    output logic    [`XBAR_NUM_MST-1:0] s_ar_ready_o,
    output mst_r_t  [`XBAR_NUM_MST-1:0] s_r_o,
    output logic    [`XBAR_NUM_MST-1:0] s_r_valid_o,
    input  logic    [`XBAR_NUM_MST-1:0] s_r_ready_i,
    // ==================================================
    // Slave ports
    // ==================================================
    output slv_ar_t [`XBAR_NUM_SLV-1:0] m_ar_o,
    output logic    [`XBAR_NUM_SLV-1:0] m_ar_valid_o,
    input  logic    [`XBAR_NUM_SLV-1:0] m_ar_ready_i,
    input  slv_r_t  [`XBAR_NUM_SLV-1:0] m_r_i,
    input  logic    [`XBAR_NUM_SLV-1:0] m_r_valid_i,
    output logic    [`XBAR_NUM_SLV-1:0] m_r_ready_o
);

    // Decoder to arbiter links, indexed by slave then master
    logic      [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0] req_push;
    xbar_req_t [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0] req;
    logic      [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST-1:0] credit_ret;

    ar_request_decoder ar_request_decoder_i (
        .aclk_i      (aclk_i),
        .rst_n_i     (rst_n_i),
        .s_ar_i      (s_ar_i),
        .s_ar_valid_i(s_ar_valid_i),
        .s_ar_ready_o(s_ar_ready_o),
        .req_push_o  (req_push),
        .req_o       (req),
        .credit_ret_i(credit_ret)
    );

    genvar s;
    generate
        for (s = 0; s < `XBAR_NUM_SLV; s = s + 1) begin : g_slv_arb
            ar_slave_arbiter ar_slave_arbiter_i (
                .aclk_i      (aclk_i),
                .rst_n_i     (rst_n_i),
                .req_push_i  (req_push[s]),
                .req_i       (req[s]),
                .credit_ret_o(credit_ret[s]),
                .m_ar_o      (m_ar_o[s]),
                .m_ar_valid_o(m_ar_valid_o[s]),
                .m_ar_ready_i(m_ar_ready_i[s])
            );
        end
    endgenerate

    r_response_router r_response_router_i (
        .aclk_i     (aclk_i),
        .rst_n_i    (rst_n_i),
        .m_r_i      (m_r_i),
        .m_r_valid_i(m_r_valid_i),
        .m_r_ready_o(m_r_ready_o),
        .s_r_o      (s_r_o),
        .s_r_valid_o(s_r_valid_o),
        .s_r_ready_i(s_r_ready_i)
    );

endmodule

//--- verilog/r_response_router.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module r_response_router
    import axi_rd_pkg::*;
    import xbar_ctrl_pkg::*;
(
    input  logic                       aclk_i,
    input  logic                       rst_n_i,
    // ==================================================
    // Slave read data channels
    // ==================================================
    input  slv_r_t [`XBAR_NUM_SLV-1:0] m_r_i,
    input  logic   [`XBAR_NUM_SLV-1:0] m_r_valid_i,
    output logic   [`XBAR_NUM_SLV-1:0] m_r_ready_o,
    // ==================================================
    // Master read data channels
    // ==================================================
    output mst_r_t [`XBAR_NUM_MST-1:0] s_r_o,
    output logic   [`XBAR_NUM_MST-1:0] s_r_valid_o,
    input  logic   [`XBAR_NUM_MST-1:0] s_r_ready_i
);

    logic     [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] hit;
    slv_idx_t [`XBAR_NUM_MST-1:0]                    sel_slv;
    logic     [`XBAR_NUM_MST-1:0]                    sel_vld;
    logic     [`XBAR_NUM_MST-1:0]                    load;
    slv_idx_t [`XBAR_NUM_MST-1:0]                    last_q;

    // Master index sits in the top ID bits
    always_comb begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            for (int s = 0; s < `XBAR_NUM_SLV; s++) begin
                hit[m][s] = m_r_valid_i[s]
                            && (mst_idx_t'(m_r_i[s].id[`XBAR_ID_W +: `XBAR_MST_IDX_W])
                                == mst_idx_t'(m));
            end
        end
    end

    // Round robin over slaves, one picker per master
    always_comb begin
        slv_idx_t cand;
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            sel_slv[m] = last_q[m];
            sel_vld[m] = 1'b0;
            for (int k = 1; k <= `XBAR_NUM_SLV; k++) begin
                cand = slv_idx_t'((int'(last_q[m]) + k) % `XBAR_NUM_SLV);
                if (!sel_vld[m] && hit[m][cand]) begin
                    sel_slv[m] = cand;
                    sel_vld[m] = 1'b1;
                end
            end
        end
    end

    // Slot takes a beat when empty or draining
    always_comb begin
        m_r_ready_o = '0;
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            load[m] = sel_vld[m] && (!s_r_valid_o[m] || s_r_ready_i[m]);
            if (load[m]) begin
                m_r_ready_o[sel_slv[m]] = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_r_valid_o <= '0;
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                last_q[m] <= slv_idx_t'(`XBAR_NUM_SLV - 1);
            end
        end else begin
            for (int m = 0; m < `XBAR_NUM_MST; m++) begin
                if (load[m]) begin
                    s_r_valid_o[m] <= 1'b1;
                    last_q[m]      <= sel_slv[m];
                end else if (s_r_ready_i[m]) begin
                    s_r_valid_o[m] <= 1'b0;
                end
            end
        end
    end

    // Output slot, master index stripped from the ID
    always_ff @(posedge aclk_i) begin
        for (int m = 0; m < `XBAR_NUM_MST; m++) begin
            if (load[m]) begin
                s_r_o[m].id   <= m_r_i[sel_slv[m]].id[`XBAR_ID_W-1:0];
                s_r_o[m].data <= m_r_i[sel_slv[m]].data;
                s_r_o[m].resp <= m_r_i[sel_slv[m]].resp;
            end
        end
    end

endmodule

//--- verilog/xbar_ctrl_pkg.sv
`include "xbar_defines.svh"

package xbar_ctrl_pkg;

    // ==================================================
    // Routing indices
    // ==================================================
    typedef logic [`XBAR_MST_IDX_W-1:0] mst_idx_t;
    typedef logic [`XBAR_SLV_IDX_W-1:0] slv_idx_t;

    // Holds 0 up to XBAR_CREDITS
    typedef logic [1:0] credit_cnt_t;

    // One queued read request
    typedef struct packed {
        axi_rd_pkg::mst_ar_t ar;
    } xbar_req_t;

    // Slave port arbiter
    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_e;

endpackage

//--- verilog/xbar_defines.svh
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// ==================================================
// Port counts
// ==================================================
`define XBAR_NUM_MST   2
`define XBAR_NUM_SLV   2

// ==================================================
// Channel widths
// ==================================================
`define XBAR_ID_W      2
`define XBAR_ADDR_W    16
`define XBAR_DATA_W    32

// Queue depth per master/slave pair, equal to its credit count
`define XBAR_CREDITS   2

// Index widths for master and slave ports
`define XBAR_MST_IDX_W 1
`define XBAR_SLV_IDX_W 1

`endif
